// ==== list.f ====
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/pipeStage.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/forwardUnit.sv
rtl/aluUnit.sv
rtl/sparcAluCore.sv
testbench/tbClock.sv
testbench/tbCore.sv

// ==== testbench/tbCore.sv ====
`timescale 1ns/1ps

module tbCore
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int NumCycles = 3000;
    localparam int ResetTimeout = 20; // Cycles
    localparam logic [5:0] LegalOp3 [13] = '{Op3Add, Op3Addx, Op3Sub, Op3Subx, Op3And,
        Op3Andn, Op3Or, Op3Orn, Op3Xor, Op3Xnor, Op3Sll, Op3Srl, Op3Sra};

    logic Clk;
    logic rst;
    logic instrValid;
    logic [XLen-1:0] instr;
    logic wbEnable;
    logic [RegAddrBits-1:0] wbRd;
    logic [XLen-1:0] wbData;
    ccT ccOut;

    logic [15:0] lfsr;
    logic [XLen-1:0] modelRegs [0:31];
    ccT modelCc;

    // One entry per cycle, in the order the outputs should show them
    logic expEnable [$];
    logic [RegAddrBits-1:0] expRd [$];
    logic [XLen-1:0] expData [$];
    ccT expCc [$];
    string expName [$];

    tbClock clock0 (
        .Clk(Clk),
        .rst(rst)
    );

    sparcAluCore dut0 (
        .Clk(Clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .wbEnable(wbEnable),
        .wbRd(wbRd),
        .wbData(wbData),
        .ccOut(ccOut)
    );

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic failRun();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [XLen-1:0] expected,
                              input logic [XLen-1:0] actual);
        assert (expected === actual)
        else
        begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            failRun();
        end
    endtask

    task automatic pushExpect(input logic en, input logic [RegAddrBits-1:0] rd,
                              input logic [XLen-1:0] data, input ccT cc, input string name);
        expEnable.push_back(en);
        expRd.push_back(rd);
        expData.push_back(data);
        expCc.push_back(cc);
        expName.push_back(name);
    endtask

    // Applies one instruction to the model state
    task automatic runModel(input logic [XLen-1:0] word, input string name);
        logic [5:0] op3;
        logic [5:0] base;
        logic [4:0] rd;
        logic [XLen-1:0] a;
        logic [XLen-1:0] b;
        logic [XLen-1:0] r;
        logic known;
        logic setsCc;
        logic cin;
        logic isAdd;
        logic isSub;
        ccT flags;
        op3 = word[24:19];
        rd = word[29:25];
        base = {op3[5], 1'b0, op3[3:0]};
        setsCc = op3[4];
        a = modelRegs[word[18:14]];
        b = word[13] ? {{19{word[12]}}, word[12:0]} : modelRegs[word[4:0]];
        known = (word[31:30] == OpArith);
        isAdd = (base == Op3Add) || (base == Op3Addx);
        isSub = (base == Op3Sub) || (base == Op3Subx);
        cin = ((base == Op3Addx) || (base == Op3Subx)) && modelCc.c;
        r = '0;
        case (base)
            Op3Add, Op3Addx: r = a + b + cin;
            Op3Sub, Op3Subx: r = a - b - cin;
            Op3And:  r = a & b;
            Op3Andn: r = a & ~b;
            Op3Or:   r = a | b;
            Op3Orn:  r = a | ~b;
            Op3Xor:  r = a ^ b;
            Op3Xnor: r = ~(a ^ b);
            Op3Sll:  r = a << b[4:0];
            Op3Srl:  r = a >> b[4:0];
            Op3Sra:  r = $signed(a) >>> b[4:0];
            default: known = 1'b0;
        endcase
        if (base[5] && setsCc)
            known = 1'b0; // No cc form of the shifts
        flags.n = r[XLen-1];
        flags.z = (r == '0);
        flags.v = 1'b0;
        flags.c = 1'b0;
        if (isAdd)
        begin
            // Overflow when the exact sum does not fit in 32 bits
            flags.v = (longint'($signed(a)) + longint'($signed(b)) + longint'(cin))
                      != longint'($signed(r));
            flags.c = (longint'(a) + longint'(b) + longint'(cin)) != longint'(r);
        end
        else if (isSub)
        begin
            flags.v = (longint'($signed(a)) - longint'($signed(b)) - longint'(cin))
                      != longint'($signed(r));
            flags.c = longint'(a) < (longint'(b) + longint'(cin)); // Borrow
        end
        if (known && rd != 0)
            modelRegs[rd] = r;
        if (known && setsCc)
            modelCc = flags;
        pushExpect(known && rd != 0, rd, r, modelCc, name);
    endtask

    task automatic makeInstr(output logic valid, output logic [XLen-1:0] word);
        logic [31:0] pick;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] iBit;
        logic [31:0] simm;
        logic [31:0] op;
        logic [31:0] op3;
        drawBits(3, pick);
        valid = (pick != 0); // Idle about one cycle in eight
        drawBits(3, rd); // r0 to r7 only
        drawBits(3, rs1);
        drawBits(3, rs2);
        drawBits(1, iBit);
        drawBits(13, simm);
        if (iBit[0] == 1'b0)
            simm[4:0] = rs2[4:0];
        drawBits(4, op3);
        op3 = LegalOp3[op3 % 13];
        drawBits(1, pick);
        if (op3[5] == 1'b0)
            op3[4] = pick[0]; // cc variant
        op = OpArith;
        drawBits(4, pick);
        if (pick == 1)
        begin
            drawBits(2, op);
            if (op[1:0] == OpArith)
                op = 2'b11;
        end
        else if (pick == 2)
            drawBits(6, op3); // Often an undefined op3
        word = {op[1:0], rd[4:0], op3[5:0], rs1[4:0], iBit[0], simm[12:0]};
        if (pick == 0)
            word = '0;
    endtask

    task automatic checkOutputs();
        logic en;
        logic [RegAddrBits-1:0] rd;
        logic [XLen-1:0] data;
        ccT cc;
        string name;
        en = expEnable.pop_front();
        rd = expRd.pop_front();
        data = expData.pop_front();
        cc = expCc.pop_front();
        name = expName.pop_front();
        checkValue({name, " wbEnable"}, en, wbEnable);
        if (en)
        begin
            checkValue({name, " wbRd"}, rd, wbRd);
            checkValue({name, " wbData"}, data, wbData);
        end
        checkValue({name, " ccOut"}, cc, ccOut);
    endtask

    initial
    begin
        int waited;
        logic valid;
        logic [XLen-1:0] word;
        instrValid = 1'b0;
        instr = '0;
        lfsr = 16'd45223;
        modelCc = '0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;

        waited = 0;
        do
        begin
            @(negedge Clk);
            checkValue("reset wbEnable", 0, wbEnable);
            checkValue("reset ccOut", 0, ccOut);
            waited++;
            if (waited > ResetTimeout)
            begin
                $display("Reset was still asserted after %0d cycles", waited);
                failRun();
            end
        end
        while (rst);

        // Outputs stay in the reset state until the first instruction arrives
        for (int i = 0; i < 3; i++)
            pushExpect(1'b0, '0, '0, '0, "after reset");

        for (int cycle = 0; cycle < NumCycles + 3; cycle++)
        begin
            @(posedge Clk);
            makeInstr(valid, word);
            if (cycle >= NumCycles)
                valid = 1'b0; // Drain the pipeline
            instrValid <= valid;
            instr <= word;
            runModel(valid ? word : '0, $sformatf("instr %0d (%h)", cycle, word));
            @(negedge Clk);
            checkOutputs();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic Clk,
    output logic rst
);

    initial
    begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk; // 20 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge Clk);
        rst <= 1'b0;
    end

endmodule

// ==== rtl/sparcAluCore.sv ====
`timescale 1ns/1ps

module sparcAluCore
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic Clk,
    input  logic rst,
    input  logic instrValid,
    input  logic [XLen-1:0] instr,
    output logic wbEnable,
    output logic [RegAddrBits-1:0] wbRd,
    output logic [XLen-1:0] wbData,
    output ccT ccOut
);

    logic [XLen-1:0] fetchWord;
    logic [XLen-1:0] ifIdInstr;

    aluOpE decAluOp;
    logic decModifyCc;
    logic decRfEnable;
    logic [RegAddrBits-1:0] decRd;
    logic [RegAddrBits-1:0] decRs1;
    logic [RegAddrBits-1:0] decRs2;
    logic decUseImm;
    logic [XLen-1:0] decImm;

    logic [XLen-1:0] rs1Data;
    logic [XLen-1:0] rs2Data;
    logic [XLen-1:0] operandA;
    logic [XLen-1:0] operandB;

    idExT idExD;
    idExT idExQ;
    exWbT exWbD;
    exWbT exWbQ;
    logic [XLen-1:0] exResult;

    assign fetchWord = instrValid ? instr : '0; // Idle cycle becomes a bubble

    pipeStage #(.payloadT(logic [XLen-1:0])) ifIdStage (
        .Clk(Clk),
        .rst(rst),
        .d(fetchWord),
        .q(ifIdInstr)
    );

    instrDecoder decoder0 (
        .instr(ifIdInstr),
        .aluOp(decAluOp),
        .modifyCc(decModifyCc),
        .rfEnable(decRfEnable),
        .rd(decRd),
        .rs1(decRs1),
        .rs2(decRs2),
        .useImm(decUseImm),
        .imm(decImm)
    );

    regFile regFile0 (
        .Clk(Clk),
        .rst(rst),
        .rs1(decRs1),
        .rs2(decRs2),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .we(exWbQ.rfEnable),
        .wa(exWbQ.rd),
        .wd(exWbQ.result)
    );

    forwardUnit forward0 (
        .rs1(decRs1),
        .rs2(decRs2),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .useImm(decUseImm),
        .imm(decImm),
        .exRfEnable(idExQ.rfEnable),
        .exRd(idExQ.rd),
        .exResult(exResult),
        .wbRfEnable(exWbQ.rfEnable),
        .wbRd(exWbQ.rd),
        .wbResult(exWbQ.result),
        .operandA(operandA),
        .operandB(operandB)
    );

    assign idExD = '{aluOp: decAluOp, modifyCc: decModifyCc, rfEnable: decRfEnable,
                     rd: decRd, operandA: operandA, operandB: operandB};

    pipeStage #(.payloadT(idExT)) idExStage (
        .Clk(Clk),
        .rst(rst),
        .d(idExD),
        .q(idExQ)
    );

    aluUnit alu0 (
        .Clk(Clk),
        .rst(rst),
        .aluOp(idExQ.aluOp),
        .modifyCc(idExQ.modifyCc),
        .operandA(idExQ.operandA),
        .operandB(idExQ.operandB),
        .result(exResult),
        .cc(ccOut)
    );

    assign exWbD = '{rfEnable: idExQ.rfEnable, rd: idExQ.rd, result: exResult};

    pipeStage #(.payloadT(exWbT)) exWbStage (
        .Clk(Clk),
        .rst(rst),
        .d(exWbD),
        .q(exWbQ)
    );

    assign wbEnable = exWbQ.rfEnable;
    assign wbRd = exWbQ.rd;
    assign wbData = exWbQ.result; // Register file takes it on the next edge

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic Clk,
    input  logic rst,
    input  aluOpE aluOp,
    input  logic modifyCc,
    input  logic [XLen-1:0] operandA,
    input  logic [XLen-1:0] operandB,
    output logic [XLen-1:0] result,
    output ccT cc
);

    logic [XLen:0] sum; // Carry or borrow in the top bit
    logic [XLen:0] wideSum; // Sign-extended operands
    logic carryIn;
    logic isAdd;
    logic isSub;
    logic signA;
    logic signB;
    logic signR;
    ccT nextCc;

    always_comb
    begin
        carryIn = 1'b0;
        sum = '0;
        isAdd = 1'b0;
        isSub = 1'b0;
        result = '0;
        case (aluOp)
            AluAdd, AluAddx:
            begin
                carryIn = (aluOp == AluAddx) ? cc.c : 1'b0; // Stored carry
                sum = {1'b0, operandA} + {1'b0, operandB} + carryIn;
                result = sum[XLen-1:0];
                isAdd = 1'b1;
            end
            AluSub, AluSubx:
            begin
                carryIn = (aluOp == AluSubx) ? cc.c : 1'b0;
                sum = {1'b0, operandA} - {1'b0, operandB} - carryIn;
                result = sum[XLen-1:0];
                isSub = 1'b1;
            end
            AluAnd:  result = operandA & operandB;
            AluAndn: result = operandA & ~operandB;
            AluOr:   result = operandA | operandB;
            AluOrn:  result = operandA | ~operandB;
            AluXor:  result = operandA ^ operandB;
            AluXnor: result = operandA ^ ~operandB;
            AluSll:  result = operandA << operandB[ShamtBits-1:0];
            AluSrl:  result = operandA >> operandB[ShamtBits-1:0];
            AluSra:  result = $signed(operandA) >>> operandB[ShamtBits-1:0];
            default: result = '0;
        endcase
    end

    assign signA = operandA[XLen-1];
    assign signB = operandB[XLen-1];
    assign signR = result[XLen-1];

    always_comb
    begin
        nextCc.n = signR;
        nextCc.z = (result == '0);
        if (isAdd)
            nextCc.v = (signA == signB) && (signR != signA); // Like signs, sign flipped
        else if (isSub)
            nextCc.v = (signA != signB) && (signR != signA);
        else
            nextCc.v = 1'b0;
        nextCc.c = (isAdd || isSub) ? sum[XLen] : 1'b0;
    end

    // PSR icc field
    always_ff @(posedge Clk)
    begin
        if (rst)
            cc <= '0;
        else if (modifyCc)
            cc <= nextCc;
    end

    assign wideSum = isSub ? {signA, operandA} - {signB, operandB} - carryIn
                           : {signA, operandA} + {signB, operandB} + carryIn;

    // Signed result out of range when the two top bits of the wide sum differ
    vFlagMatchesRange: assert property (@(posedge Clk) disable iff (rst)
        (isAdd || isSub) |-> nextCc.v == (wideSum[XLen] != wideSum[XLen-1]));

endmodule

// ==== rtl/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit
    import isaPkg::*;
(
    input  logic [RegAddrBits-1:0] rs1,
    input  logic [RegAddrBits-1:0] rs2,
    input  logic [XLen-1:0] rs1Data,
    input  logic [XLen-1:0] rs2Data,
    input  logic useImm,
    input  logic [XLen-1:0] imm,
    input  logic exRfEnable,
    input  logic [RegAddrBits-1:0] exRd,
    input  logic [XLen-1:0] exResult,
    input  logic wbRfEnable,
    input  logic [RegAddrBits-1:0] wbRd,
    input  logic [XLen-1:0] wbResult,
    output logic [XLen-1:0] operandA,
    output logic [XLen-1:0] operandB
);

    logic exHitA;
    logic exHitB;
    logic wbHitA;
    logic wbHitB;

    // rfEnable is never set for rd == 0, so no r0 check here
    assign exHitA = exRfEnable && (exRd == rs1);
    assign exHitB = exRfEnable && (exRd == rs2);
    assign wbHitA = wbRfEnable && (wbRd == rs1);
    assign wbHitB = wbRfEnable && (wbRd == rs2);

    always_comb
    begin
        if (exHitA)
            operandA = exResult; // Newest stage wins
        else if (wbHitA)
            operandA = wbResult;
        else
            operandA = rs1Data;

        if (useImm)
            operandB = imm;
        else if (exHitB)
            operandB = exResult;
        else if (wbHitB)
            operandB = wbResult;
        else
            operandB = rs2Data;

        // Relies on the decoder clearing rfEnable for rd == 0
        assert final ((rs1 != '0 || !(exHitA || wbHitA))
                      && (useImm || rs2 != '0 || !(exHitB || wbHitB)))
            else $error("Forward selected for r0");
    end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import isaPkg::*;
(
    input  logic Clk,
    input  logic rst,
    input  logic [RegAddrBits-1:0] rs1,
    input  logic [RegAddrBits-1:0] rs2,
    output logic [XLen-1:0] rs1Data,
    output logic [XLen-1:0] rs2Data,
    input  logic we,
    input  logic [RegAddrBits-1:0] wa,
    input  logic [XLen-1:0] wd
);

    localparam int NumRegs = 1 << RegAddrBits;

    logic [XLen-1:0] regs [0:NumRegs-1]; // r0 cleared on reset, never written

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NumRegs; i++)
                regs[i] <= '0;
        end
        else if (we && wa != '0)
            regs[wa] <= wd;
    end

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // r0 reads zero on both ports whatever was written
    r0ReadsZero: assert property (@(posedge Clk) disable iff (rst)
        (rs1 != '0 || rs1Data == '0) && (rs2 != '0 || rs2Data == '0));

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import isaPkg::*;
(
    input  logic [XLen-1:0] instr,
    output aluOpE aluOp,
    output logic modifyCc,
    output logic rfEnable,
    output logic [RegAddrBits-1:0] rd,
    output logic [RegAddrBits-1:0] rs1,
    output logic [RegAddrBits-1:0] rs2,
    output logic useImm,
    output logic [XLen-1:0] imm
);

    logic [1:0] op;
    logic [5:0] op3;
    logic [5:0] op3Base; // op3 with the cc bit cleared
    logic known;
    logic isShift;
    logic isArith;

    assign op = instr[OpHi:OpLo];
    assign op3 = instr[Op3Hi:Op3Lo];
    assign rd = instr[RdHi:RdLo];
    assign rs1 = instr[Rs1Hi:Rs1Lo];
    assign rs2 = instr[Rs2Hi:Rs2Lo];
    assign useImm = instr[IBit];
    assign imm = {{(XLen-13){instr[Simm13Hi]}}, instr[Simm13Hi:Simm13Lo]}; // Sign extend

    assign isArith = (op == OpArith);

    always_comb
    begin
        op3Base = op3;
        op3Base[CcBit] = 1'b0;
        known = 1'b1;
        isShift = 1'b0;
        aluOp = AluAdd;
        case (op3Base)
            Op3Add:  aluOp = AluAdd;
            Op3Addx: aluOp = AluAddx;
            Op3Sub:  aluOp = AluSub;
            Op3Subx: aluOp = AluSubx;
            Op3And:  aluOp = AluAnd;
            Op3Andn: aluOp = AluAndn;
            Op3Or:   aluOp = AluOr;
            Op3Orn:  aluOp = AluOrn;
            Op3Xor:  aluOp = AluXor;
            Op3Xnor: aluOp = AluXnor;
            Op3Sll:
            begin
                aluOp = AluSll;
                isShift = 1'b1;
            end
            Op3Srl:
            begin
                aluOp = AluSrl;
                isShift = 1'b1;
            end
            Op3Sra:
            begin
                aluOp = AluSra;
                isShift = 1'b1;
            end
            default: known = 1'b0;
        endcase
        // Shifts have no cc variant
        if (isShift && op3[CcBit])
            known = 1'b0;
    end

    assign modifyCc = isArith && known && op3[CcBit];
    assign rfEnable = isArith && known && (rd != '0); // r0 writes dropped here

endmodule

// ==== rtl/pipeStage.sv ====
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic Clk,
    input  logic rst,
    input  payloadT d,
    output payloadT q
);

    // All zeros decodes as a bubble
    always_ff @(posedge Clk)
    begin
        if (rst)
            q <= '0;
        else
            q <= d;
    end

endmodule

// ==== rtl/pipePkg.sv ====
package pipePkg;

    import isaPkg::*;

    // Integer condition codes, as held in the PSR
    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } ccT;

    // ID/EX payload
    typedef struct packed {
        aluOpE aluOp;
        logic modifyCc;
        logic rfEnable;
        logic [RegAddrBits-1:0] rd;
        logic [XLen-1:0] operandA;
        logic [XLen-1:0] operandB; // Already muxed with simm13
    } idExT;

    // EX/WB payload
    typedef struct packed {
        logic rfEnable;
        logic [RegAddrBits-1:0] rd;
        logic [XLen-1:0] result;
    } exWbT;

endpackage

// ==== rtl/isaPkg.sv ====
package isaPkg;

    localparam int XLen = 32;
    localparam int RegAddrBits = 5;
    localparam int ShamtBits = 5; // Shift count taken from operand B

    localparam logic [1:0] OpArith = 2'b10; // Format-3 arithmetic and logic

    // op3 codes of the supported instructions
    localparam logic [5:0] Op3Add = 6'b000000;
    localparam logic [5:0] Op3And = 6'b000001;
    localparam logic [5:0] Op3Or = 6'b000010;
    localparam logic [5:0] Op3Xor = 6'b000011;
    localparam logic [5:0] Op3Sub = 6'b000100;
    localparam logic [5:0] Op3Andn = 6'b000101;
    localparam logic [5:0] Op3Orn = 6'b000110;
    localparam logic [5:0] Op3Xnor = 6'b000111;
    localparam logic [5:0] Op3Addx = 6'b001000;
    localparam logic [5:0] Op3Subx = 6'b001100;
    localparam logic [5:0] Op3Sll = 6'b100101;
    localparam logic [5:0] Op3Srl = 6'b100110;
    localparam logic [5:0] Op3Sra = 6'b100111;

    localparam int CcBit = 4; // Set in op3 for the cc variant

    // Instruction word fields
    localparam int OpHi = 31;
    localparam int OpLo = 30;
    localparam int RdHi = 29;
    localparam int RdLo = 25;
    localparam int Op3Hi = 24;
    localparam int Op3Lo = 19;
    localparam int Rs1Hi = 18;
    localparam int Rs1Lo = 14;
    localparam int IBit = 13; // Register or simm13 second operand
    localparam int Simm13Hi = 12;
    localparam int Simm13Lo = 0;
    localparam int Rs2Hi = 4;
    localparam int Rs2Lo = 0;

    typedef enum logic [3:0] {
        AluAdd,
        AluAddx,
        AluSub,
        AluSubx,
        AluAnd,
        AluAndn,
        AluOr,
        AluOrn,
        AluXor,
        AluXnor,
        AluSll,
        AluSrl,
        AluSra
    } aluOpE;

endpackage
